//--- snn_data_pkg.sv
package snn_data_pkg;

    // Synaptic weight as delivered by the matcher and the prefix stage
    localparam int WEIGHT_W = 8;

    // Running pseudo-accumulator, wraps at this width
    localparam int ACC_W = 12;

    // Corrected per-timestep result
    localparam int CORR_W = 10;

    // Fibre memory address
    localparam int ADDR_W = 8;

    typedef logic [WEIGHT_W-1:0] weight_t;

    typedef logic [ACC_W-1:0] acc_t;

    typedef logic [CORR_W-1:0] corr_t;

    typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- corr_ctrl_pkg.sv
package corr_ctrl_pkg;

    localparam int DEF_TIMESTEPS = 16;

    // Slow path sequencing, one item in flight
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_DATA,
        LOAD,
        HOLD
    } seq_state_t;

endpackage

//--- lane_bus_if.sv
`timescale 1ns/1ps

interface lane_bus_if #(
    parameter int TIMESTEPS = corr_ctrl_pkg::DEF_TIMESTEPS
);

    // One-cycle strobe, lanes always take it
    logic                  load;
    snn_data_pkg::corr_t   acc_snap;
    snn_data_pkg::weight_t weight;
    // Bit n is the activity of timestep n
    logic [TIMESTEPS-1:0]  fibre_word;

    modport seq (
        output load,
        output acc_snap,
        output weight,
        output fibre_word
    );

    modport lane (
        input load,
        input acc_snap,
        input weight,
        input fibre_word
    );

    modport collector (
        input load
    );

endinterface

//--- weight_accumulator.sv
`timescale 1ns/1ps

module weight_accumulator (
    input  logic                  clk,
    input  logic                  rst,
    input  snn_data_pkg::weight_t fast_weight,
    input  logic                  fast_valid,
    output logic                  fast_ready,
    output snn_data_pkg::acc_t    acc_value
);

    logic fast_take;

    // Single-cycle add, never stalls the matcher
    assign fast_ready = 1'b1;
    assign fast_take  = fast_valid && fast_ready;

    // Wraps silently at ACC_W bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_value <= '0;
        end else if (fast_take) begin
            acc_value <= acc_value + snn_data_pkg::acc_t'(fast_weight);
        end
    end

endmodule

//--- correction_sequencer.sv
`timescale 1ns/1ps

module correction_sequencer #(
    parameter int TIMESTEPS = corr_ctrl_pkg::DEF_TIMESTEPS
) (
    input  logic                  clk,
    input  logic                  rst,

    input  snn_data_pkg::addr_t   slow_offset,
    input  snn_data_pkg::weight_t slow_weight,
    input  logic                  slow_valid,
    output logic                  slow_ready,

    input  snn_data_pkg::acc_t    acc_value,

    output snn_data_pkg::addr_t   fibre_addr,
    output logic                  fibre_read_en,
    input  logic [TIMESTEPS-1:0]  fibre_data,
    input  logic                  fibre_valid,

    input  logic                  busy,

    lane_bus_if.seq               bus
);

    corr_ctrl_pkg::seq_state_t state;

    snn_data_pkg::acc_t    snap_q;
    snn_data_pkg::weight_t weight_q;
    logic [TIMESTEPS-1:0]  word_q;
    logic                  accept;
    logic                  word_take;

    // HOLD reopens as soon as the collector lets go
    assign slow_ready = (state == corr_ctrl_pkg::IDLE || state == corr_ctrl_pkg::HOLD)
                        && !busy;
    assign accept     = slow_valid && slow_ready;
    assign word_take  = (state == corr_ctrl_pkg::WAIT_DATA) && fibre_valid;

    assign fibre_read_en = (state == corr_ctrl_pkg::FETCH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= corr_ctrl_pkg::IDLE;
        end else begin
            case (state)
                corr_ctrl_pkg::IDLE,
                corr_ctrl_pkg::HOLD: begin
                    if (accept) begin
                        state <= corr_ctrl_pkg::FETCH;
                    end else if (!busy) begin
                        state <= corr_ctrl_pkg::IDLE;
                    end
                end
                corr_ctrl_pkg::FETCH: begin
                    state <= corr_ctrl_pkg::WAIT_DATA;
                end
                corr_ctrl_pkg::WAIT_DATA: begin
                    if (fibre_valid) begin
                        state <= corr_ctrl_pkg::LOAD;
                    end
                end
                corr_ctrl_pkg::LOAD: begin
                    state <= corr_ctrl_pkg::HOLD;
                end
                default: begin
                    state <= corr_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // Snapshot is the registered sum, so a weight taken this cycle is excluded
    always_ff @(posedge clk) begin
        if (accept) begin
            weight_q   <= slow_weight;
            snap_q     <= acc_value;
            fibre_addr <= slow_offset;
        end
        if (word_take) begin
            word_q <= fibre_data;
        end
    end

    assign bus.load       = (state == corr_ctrl_pkg::LOAD);
    assign bus.acc_snap   = snap_q[snn_data_pkg::CORR_W-1:0];
    assign bus.weight     = weight_q;
    assign bus.fibre_word = word_q;

endmodule

//--- timestep_lane.sv
`timescale 1ns/1ps

module timestep_lane #(
    parameter int LANE = 0
) (
    input  logic                clk,
    input  logic                rst,
    lane_bus_if.lane            bus,
    output snn_data_pkg::corr_t result
);

    snn_data_pkg::corr_t corrected;

    // Inactive timestep did not really see this weight, take it back out
    assign corrected = bus.fibre_word[LANE] ? bus.acc_snap
                     : bus.acc_snap - snn_data_pkg::corr_t'(bus.weight);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (bus.load) begin
            result <= corrected;
        end
    end

endmodule

//--- result_collector.sv
`timescale 1ns/1ps

module result_collector #(
    parameter int TIMESTEPS = corr_ctrl_pkg::DEF_TIMESTEPS
) (
    input  logic                                    clk,
    input  logic                                    rst,
    lane_bus_if.collector                           bus,
    input  snn_data_pkg::corr_t                     lane_results [TIMESTEPS],
    output logic [TIMESTEPS*snn_data_pkg::CORR_W-1:0] result_data,
    output logic                                    result_valid,
    input  logic                                    result_ready,
    output logic                                    busy
);

    logic handshake;

    assign handshake = result_valid && result_ready;

    // Lanes register on load, so valid follows one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (bus.load) begin
            result_valid <= 1'b1;
        end else if (handshake) begin
            result_valid <= 1'b0;
        end
    end

    // Covers the gap between load and valid
    assign busy = result_valid || bus.load;

    // Lane 0 in the low bits; lanes hold until the next load
    always_comb begin
        for (int i = 0; i < TIMESTEPS; i++) begin
            result_data[i*snn_data_pkg::CORR_W +: snn_data_pkg::CORR_W] = lane_results[i];
        end
    end

endmodule

//--- corr_top.sv
`timescale 1ns/1ps

module corr_top #(
    parameter int TIMESTEPS = corr_ctrl_pkg::DEF_TIMESTEPS
) (
    input  logic                                      clk,
    input  logic                                      rst,

    // Fast path from the matcher
    input  snn_data_pkg::weight_t                     fast_weight,
    input  logic                                      fast_valid,
    output logic                                      fast_ready,

    // Slow path from the prefix stage
    input  snn_data_pkg::addr_t                       slow_offset,
    input  snn_data_pkg::weight_t                     slow_weight,
    input  logic                                      slow_valid,
    output logic                                      slow_ready,

    // Fibre memory
    output snn_data_pkg::addr_t                       fibre_addr,
    output logic                                      fibre_read_en,
    input  logic [TIMESTEPS-1:0]                      fibre_data,
    input  logic                                      fibre_valid,

    output logic [TIMESTEPS*snn_data_pkg::CORR_W-1:0] result_data,
    output logic                                      result_valid,
    input  logic                                      result_ready
);

    snn_data_pkg::acc_t  acc_value;
    snn_data_pkg::corr_t lane_results [TIMESTEPS];
    logic                busy;

    lane_bus_if #(.TIMESTEPS(TIMESTEPS)) lane_bus ();

    weight_accumulator u_acc (
        .clk         (clk),
        .rst         (rst),
        .fast_weight (fast_weight),
        .fast_valid  (fast_valid),
        .fast_ready  (fast_ready),
        .acc_value   (acc_value)
    );

    correction_sequencer #(.TIMESTEPS(TIMESTEPS)) u_seq (
        .clk           (clk),
        .rst           (rst),
        .slow_offset   (slow_offset),
        .slow_weight   (slow_weight),
        .slow_valid    (slow_valid),
        .slow_ready    (slow_ready),
        .acc_value     (acc_value),
        .fibre_addr    (fibre_addr),
        .fibre_read_en (fibre_read_en),
        .fibre_data    (fibre_data),
        .fibre_valid   (fibre_valid),
        .busy          (busy),
        .bus           (lane_bus.seq)
    );

    for (genvar i = 0; i < TIMESTEPS; i++) begin : g_lane
        timestep_lane #(.LANE(i)) u_lane (
            .clk    (clk),
            .rst    (rst),
            .bus    (lane_bus.lane),
            .result (lane_results[i])
        );
    end

    result_collector #(.TIMESTEPS(TIMESTEPS)) u_col (
        .clk          (clk),
        .rst          (rst),
        .bus          (lane_bus.collector),
        .lane_results (lane_results),
        .result_data  (result_data),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .busy         (busy)
    );

endmodule

//--- tb_corr_top.sv
`timescale 1ns/1ps

module tb_corr_top;

    localparam int TIMESTEPS   = 16;
    localparam int CLK_PERIOD  = 4;
    localparam int N_ITEMS     = 200;
    localparam int WATCHDOG_NS = N_ITEMS * 40 * CLK_PERIOD;
    localparam int CORR_MOD    = 1 << snn_data_pkg::CORR_W;
    localparam int ACC_MOD     = 1 << snn_data_pkg::ACC_W;
    localparam int DATA_W      = TIMESTEPS * snn_data_pkg::CORR_W;

    typedef logic [TIMESTEPS-1:0] word_t;

    logic                  clk = 1'b0;
    logic                  rst;
    snn_data_pkg::weight_t fast_weight;
    logic                  fast_valid;
    logic                  fast_ready;
    snn_data_pkg::addr_t   slow_offset;
    snn_data_pkg::weight_t slow_weight;
    logic                  slow_valid;
    logic                  slow_ready;
    snn_data_pkg::addr_t   fibre_addr;
    logic                  fibre_read_en;
    word_t                 fibre_data;
    logic                  fibre_valid;
    logic [DATA_W-1:0]     result_data;
    logic                  result_valid;
    logic                  result_ready;

    word_t fibre_table [256];

    // Reference model, updated at the falling edge
    int                  model_acc = 0;
    int                  snap_q [$];
    int                  weight_q [$];
    snn_data_pkg::addr_t offset_q [$];
    snn_data_pkg::addr_t read_q [$];
    int                  reads_seen = 0;
    int                  results_seen = 0;
    int                  mismatch_count = 0;
    int                  protocol_count = 0;
    int                  end_errors = 0;
    logic                hold_pending = 1'b0;
    logic                first_checked = 1'b0;
    logic [DATA_W-1:0]   held_data;

    // Stimulus and memory state
    int                  items_sent = 0;
    int                  gap = 0;
    int                  mem_delay = 0;
    logic                mem_busy = 1'b0;
    snn_data_pkg::addr_t mem_addr;
    logic                ready_seen = 1'b0;

    corr_top #(.TIMESTEPS(TIMESTEPS)) dut0 (
        .clk           (clk),
        .rst           (rst),
        .fast_weight   (fast_weight),
        .fast_valid    (fast_valid),
        .fast_ready    (fast_ready),
        .slow_offset   (slow_offset),
        .slow_weight   (slow_weight),
        .slow_valid    (slow_valid),
        .slow_ready    (slow_ready),
        .fibre_addr    (fibre_addr),
        .fibre_read_en (fibre_read_en),
        .fibre_data    (fibre_data),
        .fibre_valid   (fibre_valid),
        .result_data   (result_data),
        .result_valid  (result_valid),
        .result_ready  (result_ready)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic snn_data_pkg::corr_t expected_lane(int snap, int weight, logic active);
        int diff;
        diff = active ? snap : snap - weight;
        diff = diff % CORR_MOD;
        if (diff < 0) begin
            diff = diff + CORR_MOD;
        end
        return snn_data_pkg::corr_t'(diff);
    endfunction

    // Offsets 0 and 255 hold the all-zero and all-ones words
    function automatic snn_data_pkg::addr_t pick_offset();
        int r;
        r = $urandom_range(0, 9);
        if (r == 0) begin
            return '0;
        end
        if (r == 1) begin
            return '1;
        end
        return snn_data_pkg::addr_t'($urandom);
    endfunction

    task automatic check_result();
        int                  snap;
        int                  weight;
        snn_data_pkg::addr_t offset;
        word_t               word;
        snn_data_pkg::corr_t got;
        snn_data_pkg::corr_t exp;
        results_seen++;
        assert (snap_q.size() > 0) else begin
            $display("Result handed out with no item outstanding");
            protocol_count++;
        end
        if (snap_q.size() > 0) begin
            snap   = snap_q.pop_front();
            weight = weight_q.pop_front();
            offset = offset_q.pop_front();
            word   = fibre_table[offset];
            for (int i = 0; i < TIMESTEPS; i++) begin
                got = result_data[i*snn_data_pkg::CORR_W +: snn_data_pkg::CORR_W];
                exp = expected_lane(snap, weight, word[i]);
                assert (got == exp) else begin
                    $display("Mismatch result_data lane %0d item %0d: got %h expected %h",
                             i, results_seen - 1, got, exp);
                    mismatch_count++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!first_checked) begin
                assert (!result_valid && !fibre_read_en && slow_ready && fast_ready) else begin
                    $display("Outputs not in their idle state after reset");
                    protocol_count++;
                end
                first_checked = 1'b1;
            end
            assert (fast_ready) else begin
                $display("fast_ready went low after reset");
                protocol_count++;
            end
            if (hold_pending) begin
                assert (result_valid) else begin
                    $display("result_valid dropped without a handshake");
                    protocol_count++;
                end
                assert (result_data == held_data) else begin
                    $display("Mismatch result_data while held: got %h expected %h",
                             result_data, held_data);
                    mismatch_count++;
                end
            end
            // One item in flight from acceptance until its result handshake
            assert (slow_ready == (snap_q.size() == 0)) else begin
                $display("Mismatch slow_ready: got %h expected %h",
                         slow_ready, snap_q.size() == 0);
                mismatch_count++;
            end
            // Snapshot taken before this cycle's fast weight
            if (slow_valid && slow_ready) begin
                snap_q.push_back(model_acc);
                weight_q.push_back(int'(slow_weight));
                offset_q.push_back(slow_offset);
                read_q.push_back(slow_offset);
            end
            if (fibre_read_en) begin
                reads_seen++;
                assert (read_q.size() > 0) else begin
                    $display("Fibre read issued with no item waiting for it");
                    protocol_count++;
                end
                if (read_q.size() > 0) begin
                    assert (fibre_addr == read_q[0]) else begin
                        $display("Mismatch fibre_addr: got %h expected %h",
                                 fibre_addr, read_q[0]);
                        mismatch_count++;
                    end
                    void'(read_q.pop_front());
                end
            end
            if (result_valid && result_ready) begin
                check_result();
            end
            hold_pending = result_valid && !result_ready;
            held_data    = result_data;
            if (fast_valid && fast_ready) begin
                model_acc = (model_acc + int'(fast_weight)) % ACC_MOD;
            end
        end
    end

    task automatic drive_cycle();
        fast_valid   = ($urandom_range(0, 1) == 1);
        fast_weight  = snn_data_pkg::weight_t'($urandom);
        result_ready = ($urandom_range(0, 2) != 0);
        if (slow_valid && ready_seen) begin
            slow_valid = 1'b0;
            items_sent++;
            gap = $urandom_range(0, 3);
        end
        if (!slow_valid && items_sent < N_ITEMS) begin
            if (gap == 0) begin
                slow_valid  = 1'b1;
                slow_offset = pick_offset();
                slow_weight = snn_data_pkg::weight_t'($urandom);
            end else begin
                gap--;
            end
        end
        // Memory answers 1 to 4 cycles after the read
        fibre_valid = 1'b0;
        if (mem_busy) begin
            mem_delay--;
            if (mem_delay == 0) begin
                fibre_valid = 1'b1;
                fibre_data  = fibre_table[mem_addr];
                mem_busy    = 1'b0;
            end
        end
        if (fibre_read_en) begin
            mem_busy  = 1'b1;
            mem_addr  = fibre_addr;
            mem_delay = $urandom_range(1, 4);
        end
        ready_seen = slow_ready;
    endtask

    initial begin : stimulus
        int total;
        void'($urandom(9));
        rst          = 1'b1;
        fast_weight  = '0;
        fast_valid   = 1'b0;
        slow_offset  = '0;
        slow_weight  = '0;
        slow_valid   = 1'b0;
        fibre_data   = '0;
        fibre_valid  = 1'b0;
        result_ready = 1'b0;
        for (int i = 0; i < 256; i++) begin
            fibre_table[i] = word_t'($urandom);
        end
        fibre_table[0]   = '0;
        fibre_table[255] = '1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (results_seen < N_ITEMS) begin
            @(posedge clk);
            #1;
            drive_cycle();
        end
        repeat (4) @(posedge clk);
        assert (reads_seen == N_ITEMS) else begin
            $display("Expected %0d fibre reads but saw %0d", N_ITEMS, reads_seen);
            end_errors++;
        end
        assert (snap_q.size() == 0) else begin
            $display("%0d items were left without a result", snap_q.size());
            end_errors++;
        end
        total = mismatch_count + protocol_count + end_errors;
        $display("Errors: %0d total, %0d mismatches, %0d protocol, %0d at end",
                 total, mismatch_count, protocol_count, end_errors);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout with %0d of %0d results seen", results_seen, N_ITEMS);
        $display("Errors: %0d mismatches, %0d protocol", mismatch_count, protocol_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- corr_top.f
snn_data_pkg.sv
corr_ctrl_pkg.sv
lane_bus_if.sv
weight_accumulator.sv
correction_sequencer.sv
timestep_lane.sv
result_collector.sv
corr_top.sv
tb_corr_top.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_corr_top -f corr_top.f -o sim_corr
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_corr)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
